/* sim.f */
+incdir+verif
hw/pic_pkg.sv
hw/pic_gateway_bank.sv
hw/pic_regfile.sv
hw/pic_arb_tree.sv
hw/pic_ext_int.sv
hw/pic_ctrl.sv
verif/pic_ctrl_tb.sv

/* Makefile */
# Verilator simulation of the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= pic_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/pic_ref_model.svh */
////////////////////
// Reference model of the interrupt controller
// Registers, edge pending bits and winner selection
////////////////////
`ifndef PIC_REF_MODEL_SVH
`define PIC_REF_MODEL_SVH

prio_t              m_prio [NUM_INT];
logic [NUM_INT-1:0] m_en;
logic [NUM_INT-1:0] m_pol;     // 1 for active low
logic [NUM_INT-1:0] m_type;    // 1 for edge
logic [NUM_INT-1:0] m_pend;
logic [NUM_INT-1:0] m_level;   // Source levels as driven
logic               m_order;

task automatic reset_regs();
   for (int i = 0; i < NUM_INT; i++) begin
      m_prio[i] = '0;
   end
   m_en    = '0;
   m_pol   = '0;
   m_type  = '0;
   m_pend  = '0;
   m_level = '0;
   m_order = 1'b0;
endtask

// Source level after polarity, reserved slot never active
function automatic logic [NUM_INT-1:0] active_levels();
   logic [NUM_INT-1:0] act;
   act    = m_level ^ m_pol;
   act[0] = 1'b0;
   return act;
endfunction

function automatic logic [NUM_INT-1:0] gateway_out();
   return active_levels() | (m_pend & m_type);
endfunction

// An active level sets the pending bit whatever the gateway type
task automatic latch_edges();
   m_pend = m_pend | active_levels();
endtask

task automatic apply_write(input word_t offs, input int src, input word_t data);
   if (offs == CONFIG_OFFS) begin
      m_order = data[0];
   end else if (src != 0) begin
      case (offs)
         PRIORITY_OFFS:  m_prio[src] = data[3:0];
         ENABLE_OFFS:    m_en[src] = data[0];
         GW_CONFIG_OFFS: begin
            m_pol[src]  = data[0];
            m_type[src] = data[1];
         end
         GW_CLEAR_OFFS:  m_pend[src] = 1'b0;
         default:        ;
      endcase
   end
   latch_edges();   // New polarity may make a source active
endtask

function automatic word_t expect_read(input word_t offs, input int src);
   logic [NUM_INT-1:0] req;
   word_t              value;
   req = gateway_out();
   case (offs)
      PRIORITY_OFFS:  value = word_t'(m_prio[src]);
      PEND_OFFS:      value = word_t'(req);   // Group 0 holds all 32 sources
      ENABLE_OFFS:    value = word_t'(m_en[src]);
      GW_CONFIG_OFFS: value = word_t'({m_type[src], m_pol[src]});
      CONFIG_OFFS:    value = word_t'(m_order);
      default:        value = '0;
   endcase
   return value;
endfunction

// Highest effective priority wins, lowest ID on ties, ID 0 when idle
task automatic pick_winner(output id_t id, output prio_t eff);
   logic [NUM_INT-1:0] req;
   prio_t              p;
   req = gateway_out();
   id  = '0;
   eff = '0;
   for (int i = 1; i < NUM_INT; i++) begin
      p = m_order ? ~m_prio[i] : m_prio[i];
      if (req[i] && m_en[i] && p > eff) begin
         id  = id_t'(i);
         eff = p;
      end
   end
endtask

task automatic expected_outputs(input prio_t thr, input prio_t cur, output id_t id,
                                output prio_t pl, output logic req, output logic wake);
   prio_t eff;
   prio_t thr_eff;
   prio_t cur_eff;
   pick_winner(id, eff);
   thr_eff = m_order ? ~thr : thr;
   cur_eff = m_order ? ~cur : cur;
   pl      = m_order ? ~eff : eff;
   req     = (eff > thr_eff) && (eff > cur_eff);
   wake    = m_order ? (pl == prio_t'(0)) : (pl == PRIO_MAX);
endtask

`endif

/* verif/pic_ctrl_tb.sv */
`timescale 1ns/1ps
////////////////////
// Testbench for the interrupt controller
// Random register, source and threshold stimulus against a reference model
////////////////////

module pic_ctrl_tb;
   import pic_pkg::*;

   localparam int    NUM_INT      = 32;
   localparam word_t BASE         = PIC_BASE_ADDR;
   localparam int    CLK_PERIOD   = 40;
   localparam int    N_RB         = 40;   // Read-back iterations
   localparam int    N_ARB        = 25;   // Iterations per arbitration run
   localparam int    N_EDGE       = NUM_INT - 1;   // One pulse per source
   localparam int    ARB_CYCLES   = 1 + 3*(NUM_INT-1) + 7*N_ARB;
   localparam int    EDGE_CYCLES  = 2*(NUM_INT-1) + 8 + 8*N_EDGE;
   localparam int    TOTAL_CYCLES = 4 + 2*(N_RB+1) + 4*ARB_CYCLES + EDGE_CYCLES;

   logic               clk = 1'b0;
   logic               arst_n;
   word_t              picm_addr;
   word_t              picm_wr_data;
   logic               picm_wren;
   logic               picm_rden;
   prio_t              meipt;
   prio_t              meicurpl;
   logic [NUM_INT-1:0] extintsrc_req;
   word_t              picm_rd_data;
   id_t                claimid;
   prio_t              pl;
   logic               mexintpend;
   logic               mhwakeup;

   logic [63:0] rng_state = 64'd98;
   int          n_checks  = 0;
   int          n_errors  = 0;
   int          t_checks  = 0;
   int          t_errors  = 0;

   `include "pic_ref_model.svh"

   pic_ctrl #(
      .NUM_INT   (NUM_INT),
      .BASE_ADDR (BASE)
   ) u_pic_ctrl (
      .clk           (clk),
      .arst_n        (arst_n),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .extintsrc_req (extintsrc_req),
      .picm_rd_data  (picm_rd_data),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////
   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
      return rng_state[63:32];   // Upper bits have the longest period
   endfunction

   function automatic int rand_below(input int n);
      return int'(lcg_next() % 32'(n));
   endfunction

   task automatic compare(input string name, input word_t got, input word_t exp);
      n_checks++;
      t_checks++;
      if (got !== exp) begin
         $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t ns", name, exp, got, $time);
         n_errors++;
         t_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("Test %-22s %0d checks, %0d errors", name, t_checks, t_errors);
      t_checks = 0;
      t_errors = 0;
   endtask

   // Every task starts and ends 2 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   task automatic bus_write(input word_t addr, input word_t data);
      picm_addr    = addr;
      picm_wr_data = data;
      picm_wren    = 1'b1;
      wait_cycles(1);
      picm_wren    = 1'b0;
   endtask

   task automatic bus_read(input word_t addr, output word_t data);
      picm_addr = addr;
      picm_rden = 1'b1;
      wait_cycles(1);
      picm_rden = 1'b0;
      data      = picm_rd_data;   // Valid in the cycle after capture
   endtask

   task automatic reg_write(input word_t offs, input int src, input word_t data);
      bus_write(BASE + offs + word_t'(4*src), data);
      apply_write(offs, src, data);
   endtask

   task automatic reg_read(input word_t offs, input int src);
      word_t got;
      bus_read(BASE + offs + word_t'(4*src), got);
      compare("picm_rd_data", got, expect_read(offs, src));
   endtask

   task automatic set_levels(input logic [NUM_INT-1:0] lv);
      extintsrc_req = lv;
      m_level       = lv;
      latch_edges();
   endtask

   ////////////////////
   // Tests
   ////////////////////
   task automatic run_read_back();
      word_t offs;
      int    src;
      for (int n = 0; n < N_RB; n++) begin
         case (rand_below(4))
            0:       offs = PRIORITY_OFFS;
            1:       offs = ENABLE_OFFS;
            2:       offs = GW_CONFIG_OFFS;
            default: offs = CONFIG_OFFS;
         endcase
         src = (offs == CONFIG_OFFS) ? 0 : rand_below(NUM_INT);
         reg_write(offs, src, lcg_next());
         reg_read(offs, src);
      end
      reg_write(PRIORITY_OFFS, 0, 32'hFFFF_FFFF);   // Reserved slot stays zero
      reg_read(PRIORITY_OFFS, 0);
      finish_test("register read-back");
   endtask

   task automatic run_arbitration(input logic order, input logic use_thr, input string name);
      int    src;
      prio_t thr;
      prio_t cur;
      id_t   exp_id;
      prio_t exp_pl;
      logic  exp_req;
      logic  exp_wake;
      reg_write(CONFIG_OFFS, 0, word_t'(order));
      for (int s = 1; s < NUM_INT; s++) begin
         reg_write(GW_CONFIG_OFFS, s, 32'h0);   // Level type, active high
         reg_write(PRIORITY_OFFS, s, lcg_next());
         reg_write(ENABLE_OFFS, s, lcg_next());
      end
      for (int n = 0; n < N_ARB; n++) begin
         repeat (2) begin
            src = 1 + rand_below(NUM_INT - 1);
            reg_write(PRIORITY_OFFS, src, lcg_next());
            reg_write(ENABLE_OFFS, src, lcg_next());
         end
         set_levels(NUM_INT'(lcg_next() & lcg_next()));
         if (use_thr) begin
            thr = prio_t'(lcg_next());
            cur = prio_t'(lcg_next());
         end else begin
            thr = order ? PRIO_MAX : prio_t'(0);   // Lowest level in either order
            cur = thr;
         end
         meipt    = thr;
         meicurpl = cur;
         wait_cycles(3);
         expected_outputs(thr, cur, exp_id, exp_pl, exp_req, exp_wake);
         compare("claimid", word_t'(claimid), word_t'(exp_id));
         compare("pl", word_t'(pl), word_t'(exp_pl));
         compare("mexintpend", word_t'(mexintpend), word_t'(exp_req));
         compare("mhwakeup", word_t'(mhwakeup), word_t'(exp_wake));
      end
      finish_test(name);
   endtask

   task automatic run_edge_gateway();
      logic [NUM_INT-1:0] idle;
      logic [NUM_INT-1:0] pulse;
      int                 src;
      idle    = NUM_INT'(lcg_next());
      idle[0] = 1'b0;
      reg_write(CONFIG_OFFS, 0, 32'h0);
      for (int s = 1; s < NUM_INT; s++) begin
         reg_write(GW_CONFIG_OFFS, s, {30'h0, 1'b1, idle[s]});   // Edge type
      end
      set_levels(idle);   // Low-active sources rest high
      wait_cycles(3);
      for (int s = 1; s < NUM_INT; s++) begin
         reg_write(GW_CLEAR_OFFS, s, 32'h0);
      end
      wait_cycles(3);
      reg_read(PEND_OFFS, 0);
      for (int n = 0; n < N_EDGE; n++) begin
         src        = 1 + n;
         pulse      = idle;
         pulse[src] = ~idle[src];
         set_levels(pulse);
         wait_cycles(1);
         set_levels(idle);
         wait_cycles(3);
         reg_read(PEND_OFFS, 0);   // Latched after the pulse
         bus_write(BASE + GW_CLEAR_OFFS + word_t'(4*src), 32'h0);
         reg_read(PEND_OFFS, 0);   // Still set while the clear pulse is out
         apply_write(GW_CLEAR_OFFS, src, 32'h0);
         reg_read(PEND_OFFS, 0);
      end
      finish_test("edge gateway");
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin
      arst_n        = 1'b0;
      picm_addr     = '0;
      picm_wr_data  = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      meipt         = '0;
      meicurpl      = '0;
      extintsrc_req = '0;
      reset_regs();
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
      compare("claimid", word_t'(claimid), 32'h0);
      compare("pl", word_t'(pl), 32'h0);
      compare("mexintpend", word_t'(mexintpend), 32'h0);
      compare("mhwakeup", word_t'(mhwakeup), 32'h0);
      finish_test("reset values");
      run_read_back();
      run_arbitration(1'b0, 1'b0, "level arbitration");
      run_arbitration(1'b0, 1'b1, "threshold");
      run_arbitration(1'b1, 1'b0, "inverted arbitration");
      run_arbitration(1'b1, 1'b1, "inverted threshold");
      run_edge_gateway();
      $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Ends a stuck run
   initial begin
      #((TOTAL_CYCLES + 200) * CLK_PERIOD);
      $display("Watchdog expired before all tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* hw/pic_ctrl.sv */
`timescale 1ns/1ps
////////////////////
// Interrupt controller top
// Register port, gateways, compare tree and core outputs
////////////////////

module pic_ctrl #(
   parameter int             NUM_INT   = 32,   // Includes reserved slot 0
   parameter pic_pkg::word_t BASE_ADDR = pic_pkg::PIC_BASE_ADDR
) (
   input  logic               clk,
   input  logic               arst_n,
   input  pic_pkg::word_t     picm_addr,
   input  pic_pkg::word_t     picm_wr_data,
   input  logic               picm_wren,
   input  logic               picm_rden,
   input  pic_pkg::prio_t     meipt,          // Threshold
   input  pic_pkg::prio_t     meicurpl,       // Level in service
   input  logic [NUM_INT-1:0] extintsrc_req,  // Asynchronous device levels
   output pic_pkg::word_t     picm_rd_data,
   output pic_pkg::id_t       claimid,
   output pic_pkg::prio_t     pl,
   output logic               mexintpend,
   output logic               mhwakeup
);
   import pic_pkg::*;

   prio_t              int_prio [NUM_INT];
   logic [NUM_INT-1:0] int_enable;
   logic [NUM_INT-1:0] gw_polarity;
   logic [NUM_INT-1:0] gw_type;
   logic [NUM_INT-1:0] gw_clear;
   logic [NUM_INT-1:0] int_req;        // Gateway outputs
   logic               prio_order;
   id_t                win_id;
   prio_t              win_prio;

   pic_regfile #(
      .NUM_INT   (NUM_INT),
      .BASE_ADDR (BASE_ADDR)
   ) u_regfile (
      .clk          (clk),
      .arst_n       (arst_n),
      .picm_addr    (picm_addr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .int_req      (int_req),
      .picm_rd_data (picm_rd_data),
      .int_prio     (int_prio),
      .int_enable   (int_enable),
      .gw_polarity  (gw_polarity),
      .gw_type      (gw_type),
      .gw_clear     (gw_clear),
      .prio_order   (prio_order)
   );

   pic_gateway_bank #(
      .NUM_INT (NUM_INT)
   ) u_gateway_bank (
      .clk           (clk),
      .arst_n        (arst_n),
      .extintsrc_req (extintsrc_req),
      .gw_polarity   (gw_polarity),
      .gw_type       (gw_type),
      .gw_clear      (gw_clear),
      .int_req       (int_req)
   );

   pic_arb_tree #(
      .NUM_INT (NUM_INT)
   ) u_arb_tree (
      .int_req    (int_req),
      .int_enable (int_enable),
      .int_prio   (int_prio),
      .prio_order (prio_order),
      .win_id     (win_id),
      .win_prio   (win_prio)
   );

   pic_ext_int u_ext_int (
      .clk        (clk),
      .arst_n     (arst_n),
      .win_id     (win_id),
      .win_prio   (win_prio),
      .meipt      (meipt),
      .meicurpl   (meicurpl),
      .prio_order (prio_order),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

/* hw/pic_ext_int.sv */
`timescale 1ns/1ps
////////////////////
// Threshold compare and registered core-facing outputs
////////////////////

module pic_ext_int (
   input  logic           clk,
   input  logic           arst_n,
   input  pic_pkg::id_t   win_id,
   input  pic_pkg::prio_t win_prio,
   input  pic_pkg::prio_t meipt,
   input  pic_pkg::prio_t meicurpl,
   input  logic           prio_order,
   output pic_pkg::id_t   claimid,
   output pic_pkg::prio_t pl,
   output logic           mexintpend,
   output logic           mhwakeup
);
   import pic_pkg::*;

   prio_t thr_eff;    // Threshold in effective encoding
   prio_t cur_eff;    // Current level in effective encoding
   prio_t pl_d;
   prio_t wake_lvl;
   logic  req_d;
   logic  wake_d;
   logic  seen_q;     // Some winner had a nonzero priority

   assign thr_eff = prio_order ? ~meipt : meipt;
   assign cur_eff = prio_order ? ~meicurpl : meicurpl;

   // Must beat both the threshold and the level being serviced
   assign req_d = (win_prio > thr_eff) && (win_prio > cur_eff);

   // Back to the programmed encoding
   assign pl_d     = prio_order ? ~win_prio : win_prio;
   assign wake_lvl = prio_order ? prio_t'(0) : PRIO_MAX;
   assign wake_d   = pl_d == wake_lvl;

   ////////////////////
   // Output flops
   ////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
         seen_q     <= 1'b0;
      end else begin
         claimid    <= win_id;
         pl         <= pl_d;
         mexintpend <= req_d;
         mhwakeup   <= wake_d;
         seen_q     <= seen_q | (win_prio != '0);
      end
   end

   // No request reaches the core before any source has won with a priority
   no_early_req: assert property (@(posedge clk) disable iff (!arst_n)
      !seen_q |-> !mexintpend);

endmodule

/* hw/pic_arb_tree.sv */
`timescale 1ns/1ps
////////////////////
// Single-cycle compare tree over all sources
// Picks the highest effective priority, lowest ID on ties
////////////////////

module pic_arb_tree #(
   parameter int NUM_INT = 32
) (
   input  logic               [NUM_INT-1:0] int_req,
   input  logic               [NUM_INT-1:0] int_enable,
   input  pic_pkg::prio_t     int_prio [NUM_INT],
   input  logic               prio_order,
   output pic_pkg::id_t       win_id,
   output pic_pkg::prio_t     win_prio
);
   import pic_pkg::*;

   localparam int LEVELS = $clog2(NUM_INT);
   localparam int LEAVES = 1 << LEVELS;   // Padded to a power of two

   typedef struct packed {
      id_t   id;
      prio_t prio;
   } cand_t;

   // Heap order, node k feeds from 2k+1 (left) and 2k+2 (right)
   cand_t node [2*LEAVES-1];

   // Left wins unless right is strictly higher
   function automatic cand_t pick(cand_t a, cand_t b);
      return (b.prio > a.prio) ? b : a;
   endfunction

   ////////////////////
   // Leaves
   ////////////////////
   for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
      if (i < NUM_INT) begin : g_src
         prio_t eff;
         logic  live;
         assign eff  = prio_order ? ~int_prio[i] : int_prio[i];   // Inverted order
         assign live = int_req[i] & int_enable[i];
         assign node[LEAVES-1+i] = {id_t'(i), live ? eff : prio_t'(0)};
      end else begin : g_pad
         assign node[LEAVES-1+i] = {id_t'(i), prio_t'(0)};   // Never beats a left operand
      end
   end

   ////////////////////
   // Compare levels
   ////////////////////
   for (genvar k = 0; k < LEAVES-1; k++) begin : g_node
      assign node[k] = pick(node[2*k+1], node[2*k+2]);
   end

   assign win_id   = node[0].id;
   assign win_prio = node[0].prio;   // Effective encoding

endmodule

/* hw/pic_regfile.sv */
`timescale 1ns/1ps
////////////////////
// Register port: request capture, decode, config registers, read mux
////////////////////

module pic_regfile #(
   parameter int             NUM_INT   = 32,
   parameter pic_pkg::word_t BASE_ADDR = pic_pkg::PIC_BASE_ADDR
) (
   input  logic               clk,
   input  logic               arst_n,
   input  pic_pkg::word_t     picm_addr,
   input  pic_pkg::word_t     picm_wr_data,
   input  logic               picm_wren,
   input  logic               picm_rden,
   input  logic [NUM_INT-1:0] int_req,
   output pic_pkg::word_t     picm_rd_data,
   output pic_pkg::prio_t     int_prio [NUM_INT],
   output logic [NUM_INT-1:0] int_enable,
   output logic [NUM_INT-1:0] gw_polarity,
   output logic [NUM_INT-1:0] gw_type,
   output logic [NUM_INT-1:0] gw_clear,
   output logic               prio_order
);
   import pic_pkg::*;

   localparam int IDX_BITS = $clog2(NUM_INT);   // Word index within a region
   localparam int GRPS     = (NUM_INT + 31) / 32;   // Pending words

   localparam word_t PRIO_BASE  = BASE_ADDR + PRIORITY_OFFS;
   localparam word_t PEND_BASE  = BASE_ADDR + PEND_OFFS;
   localparam word_t EN_BASE    = BASE_ADDR + ENABLE_OFFS;
   localparam word_t CFG_ADDR   = BASE_ADDR + CONFIG_OFFS;
   localparam word_t GWCFG_BASE = BASE_ADDR + GW_CONFIG_OFFS;
   localparam word_t GWCLR_BASE = BASE_ADDR + GW_CLEAR_OFFS;

   logic                 wren_q;
   logic                 rden_q;
   word_t                addr_q;
   word_t                data_q;
   logic [IDX_BITS-1:0]  idx;
   logic                 hit_prio;
   logic                 hit_pend;
   logic                 hit_en;
   logic                 hit_cfg;
   logic                 hit_gwcfg;
   logic                 hit_gwclr;
   logic [32*GRPS-1:0]   pend_ext;
   word_t                rd_word;

   ////////////////////
   // Request capture
   ////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= picm_wren;
         rden_q <= picm_rden;
      end
   end

   always_ff @(posedge clk) begin
      if (picm_wren || picm_rden) begin
         addr_q <= picm_addr;
      end
      if (picm_wren) begin
         data_q <= picm_wr_data;
      end
   end

   ////////////////////
   // Address decode
   ////////////////////
   assign idx = addr_q[IDX_BITS+1:2];

   assign hit_prio  = addr_q[31:IDX_BITS+2] == PRIO_BASE[31:IDX_BITS+2];
   assign hit_en    = addr_q[31:IDX_BITS+2] == EN_BASE[31:IDX_BITS+2];
   assign hit_gwcfg = addr_q[31:IDX_BITS+2] == GWCFG_BASE[31:IDX_BITS+2];
   assign hit_gwclr = addr_q[31:IDX_BITS+2] == GWCLR_BASE[31:IDX_BITS+2];
   assign hit_pend  = addr_q[31:6] == PEND_BASE[31:6];   // Up to 16 pending words
   assign hit_cfg   = addr_q == CFG_ADDR;

   ////////////////////
   // Configuration registers
   ////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         int_prio    <= '{default: '0};
         int_enable  <= '0;
         gw_polarity <= '0;
         gw_type     <= '0;
         gw_clear    <= '0;
         prio_order  <= 1'b0;
      end else begin
         gw_clear <= '0;   // Clear is a single-cycle pulse
         if (wren_q && hit_cfg) begin
            prio_order <= data_q[0];
         end
         // Loop starts at 1 so the reserved slot stays zero
         for (int i = 1; i < NUM_INT; i++) begin
            if (wren_q && idx == IDX_BITS'(i)) begin
               if (hit_prio) begin
                  int_prio[i] <= data_q[PRIO_BITS-1:0];
               end
               if (hit_en) begin
                  int_enable[i] <= data_q[0];
               end
               if (hit_gwcfg) begin
                  gw_polarity[i] <= data_q[0];   // 1 for active low
                  gw_type[i]     <= data_q[1];   // 1 for edge
               end
               if (hit_gwclr) begin
                  gw_clear[i] <= 1'b1;
               end
            end
         end
      end
   end

   ////////////////////
   // Read-back
   ////////////////////
   assign pend_ext = (32*GRPS)'(int_req);

   always_comb begin
      rd_word = '0;
      if (hit_pend) begin
         for (int g = 0; g < GRPS; g++) begin
            if (addr_q[5:2] == 4'(g)) begin
               rd_word = pend_ext[32*g +: 32];
            end
         end
      end else if (hit_cfg) begin
         rd_word = word_t'(prio_order);
      end else begin
         for (int i = 0; i < NUM_INT; i++) begin
            if (idx == IDX_BITS'(i)) begin
               if (hit_prio) begin
                  rd_word = word_t'(int_prio[i]);
               end
               if (hit_en) begin
                  rd_word = word_t'(int_enable[i]);
               end
               if (hit_gwcfg) begin
                  rd_word = word_t'({gw_type[i], gw_polarity[i]});
               end
            end
         end
      end
   end

   assign picm_rd_data = rden_q ? rd_word : '0;   // Zero outside a read cycle

   // Core never issues a read and a write in the same cycle
   strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(picm_wren && picm_rden));

endmodule

/* hw/pic_gateway_bank.sv */
`timescale 1ns/1ps
////////////////////
// Source synchronizers and per-source level/edge gateways
////////////////////

module pic_gateway_bank #(
   parameter int NUM_INT = 32
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [NUM_INT-1:0] extintsrc_req,
   input  logic [NUM_INT-1:0] gw_polarity,
   input  logic [NUM_INT-1:0] gw_type,
   input  logic [NUM_INT-1:0] gw_clear,
   output logic [NUM_INT-1:0] int_req
);

   // Slot 0 is reserved and never requests
   localparam logic [NUM_INT-1:0] SRC_MASK = {{(NUM_INT-1){1'b1}}, 1'b0};

   logic [NUM_INT-1:0] sync_q1;
   logic [NUM_INT-1:0] sync_q2;
   logic [NUM_INT-1:0] active;    // Input level after polarity
   logic [NUM_INT-1:0] pend_q;    // Edge pending, held until cleared
   logic [NUM_INT-1:0] pend_d;

   ////////////////////
   // Two-flop synchronizer
   ////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= extintsrc_req & SRC_MASK;
         sync_q2 <= sync_q1;
      end
   end

   ////////////////////
   // Gateways
   ////////////////////
   assign active = (sync_q2 ^ gw_polarity) & SRC_MASK;

   // Set on the active level, drop only on a clear pulse
   assign pend_d = active | (pend_q & ~gw_clear);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_q <= '0;
      end else begin
         pend_q <= pend_d;
      end
   end

   // Level type passes the active level, edge type adds the latched bit
   assign int_req = active | (pend_q & gw_type);

   // A latched edge only goes away through the clear register
   pend_fall_on_clear: assert property (@(posedge clk) disable iff (!arst_n)
      (($past(pend_q) & ~pend_q & ~$past(gw_clear)) == '0));

endmodule

/* hw/pic_pkg.sv */
////////////////////
// Shared widths, types and register map of the interrupt controller
////////////////////

package pic_pkg;

   ////////////////////
   // Field widths
   ////////////////////
   localparam int PRIO_BITS = 4;   // Priority, threshold and level fields
   localparam int ID_BITS   = 8;   // Claim ID, up to 256 sources

   typedef logic [PRIO_BITS-1:0] prio_t;
   typedef logic [ID_BITS-1:0]   id_t;
   typedef logic [31:0]          word_t;   // Register port address and data

   // Highest priority in the programmed encoding
   localparam prio_t PRIO_MAX = prio_t'((1 << PRIO_BITS) - 1);

   ////////////////////
   // Register map
   ////////////////////
   localparam word_t PIC_BASE_ADDR = 32'hF00C_0000;   // Default block base

   // Region offsets from the block base
   localparam word_t PRIORITY_OFFS  = 32'h0000_0000;   // One word per source
   localparam word_t PEND_OFFS      = 32'h0000_1000;   // Read only, 32 sources per word
   localparam word_t ENABLE_OFFS    = 32'h0000_2000;   // One word per source
   localparam word_t CONFIG_OFFS    = 32'h0000_3000;   // Single word, priority order
   localparam word_t GW_CONFIG_OFFS = 32'h0000_4000;   // Polarity and type per source
   localparam word_t GW_CLEAR_OFFS  = 32'h0000_5000;   // Write only, clears edge pending

endpackage
